//--- block_ram.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module block_ram #(
	parameter int depth = `RS_BANK_DEPTH,   // words held
	parameter int width = 8                 // bits per word
) (
	input  logic               clk,
	input  logic               we,          // write strobe
	input  logic               re,          // read strobe
	input  rs_pkg::byte_idx_t  wr_addr,
	input  rs_pkg::byte_idx_t  rd_addr,
	input  logic [width-1:0]   wr_data,
	output logic [width-1:0]   rd_data      // valid the clock after re
);

	logic [width-1:0] mem [depth];          // storage array

	////////////////////
	// write port
	////////////////////
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	////////////////////
	// read port, one clock latency
	////////////////////
	always_ff @(posedge clk)
	begin
		if (re)
			rd_data <= mem[rd_addr];        // holds last word when idle
	end

endmodule

//--- gf_pkg.sv
`include "rs_config.svh"

package gf_pkg;

	typedef logic [7:0] gf_elem_t;    // one field symbol

	////////////////////
	// multiply by alpha
	////////////////////
	function automatic gf_elem_t gf_xtime(gf_elem_t a);
		gf_elem_t r;
		r = {a[6:0], 1'b0};            // shift up one degree
		if (a[7])
			r = r ^ `GF_POLY;          // fold x^8 back into the field
		return r;
	endfunction

	// a * alpha^p as p single alpha steps for p up to 254
	function automatic gf_elem_t gf_mul_alpha_pow(gf_elem_t a, int unsigned p);
		gf_elem_t r;
		r = a;
		for (int i = 0; i < 255; i++)
		begin
			if (i < p)
				r = gf_xtime(r);
		end
		return r;
	endfunction

	////////////////////
	// full product
	////////////////////
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh  = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ sh;        // add a*x^i term
			sh = gf_xtime(sh);
		end
		return acc;
	endfunction

endpackage

//--- input_stage.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module input_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               ce,          // one strobe per received byte
	input  gf_pkg::gf_elem_t   in_byte,
	output logic               we0,         // bank 0 write
	output logic               we1,         // bank 1 write
	output rs_pkg::byte_idx_t  wr_addr,
	output gf_pkg::gf_elem_t   wr_data,
	output logic               sym_strobe,  // ce delayed one clock
	output logic               sym_first,   // byte 0 of the block
	output logic               sym_last,    // byte RS_N-1 of the block
	output gf_pkg::gf_elem_t   sym_byte,
	output rs_pkg::bank_t      fill_bank    // bank taking the current block
);

	import rs_pkg::*;
	import gf_pkg::*;

	localparam byte_idx_t last_idx = byte_idx_t'(`RS_N - 1);
	localparam byte_idx_t data_end = byte_idx_t'(`RS_K);

	byte_idx_t cnt;                         // position of the byte now arriving
	logic      is_data;                     // below RS_K, parity is dropped

	////////////////////
	// bank write, same edge as ce
	////////////////////
	assign is_data = (cnt < data_end);
	assign we0     = ce && is_data && (fill_bank == 1'b0);
	assign we1     = ce && is_data && (fill_bank == 1'b1);
	assign wr_addr = cnt;
	assign wr_data = in_byte;

	// byte counter and ping-pong toggle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt       <= '0;
			fill_bank <= 1'b0;
		end
		else if (ce)
		begin
			if (cnt == last_idx)
			begin
				cnt       <= '0;            // next byte opens a new block
				fill_bank <= ~fill_bank;    // switch on the last byte
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

	////////////////////
	// symbol forward to syndrome unit
	////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sym_strobe <= 1'b0;
			sym_first  <= 1'b0;
			sym_last   <= 1'b0;
		end
		else
		begin
			sym_strobe <= ce;
			sym_first  <= ce && (cnt == '0);
			sym_last   <= ce && (cnt == last_idx);
		end
	end

	always_ff @(posedge clk)
	begin
		if (ce)
			sym_byte <= in_byte;            // payload, follows sym_strobe
	end

	// input spacing must leave room for the output side
	a_ce_spacing : assert property (@(posedge clk) disable iff (reset) ce |=> !ce)
		else $error("input_stage: ce on consecutive clocks");

endmodule

//--- out_stage.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module out_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               s_ready,     // a finished block is waiting
	input  logic               ok_in,       // its verdict
	input  rs_pkg::bank_t      done_bank,   // and where it is stored
	output logic               re0,
	output logic               re1,
	output rs_pkg::byte_idx_t  rd_addr,
	input  gf_pkg::gf_elem_t   rd_data0,
	input  gf_pkg::gf_elem_t   rd_data1,
	output gf_pkg::gf_elem_t   out_byte,
	output logic               ceo,         // one per output byte
	output logic               valid_out,   // first ceo through last ceo
	output logic               block_ok
);

	import rs_pkg::*;

	localparam int        sp_w     = $clog2(`RS_OUT_SPACING);
	localparam logic [sp_w-1:0] rd_slot  = sp_w'(`RS_OUT_SPACING - 2); // read phase
	localparam logic [sp_w-1:0] sp_last  = sp_w'(`RS_OUT_SPACING - 1);
	localparam byte_idx_t last_rd  = byte_idx_t'(`RS_K - 1);

	logic [sp_w-1:0] space_cnt;             // position in the spacing window
	byte_idx_t       rd_ptr;                // next byte to read
	bank_t           bank_q;                // bank being played out
	logic            reading;               // reads still to issue
	logic            re;

	////////////////////
	// read request, one clock ahead of ceo
	////////////////////
	assign re      = reading && (space_cnt == rd_slot);
	assign re0     = re && (bank_q == 1'b0);
	assign re1     = re && (bank_q == 1'b1);
	assign rd_addr = rd_ptr;
	assign out_byte = bank_q ? rd_data1 : rd_data0;   // RAM output already registered

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			space_cnt <= '0;
			rd_ptr    <= '0;
			bank_q    <= 1'b0;
			block_ok  <= 1'b0;
			reading   <= 1'b0;
		end
		else if (s_ready)
		begin
			space_cnt <= '0;                // first read lands RS_OUT_SPACING-1 later
			rd_ptr    <= '0;
			bank_q    <= done_bank;
			block_ok  <= ok_in;             // held for the whole block
			reading   <= 1'b1;
		end
		else if (reading)
		begin
			space_cnt <= (space_cnt == sp_last) ? '0 : space_cnt + 1'b1;
			if (re)
			begin
				rd_ptr <= rd_ptr + 1'b1;
				if (rd_ptr == last_rd)
					reading <= 1'b0;        // RS_K reads issued
			end
		end
	end

	////////////////////
	// output strobes
	////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			ceo       <= 1'b0;
			valid_out <= 1'b0;
		end
		else
		begin
			ceo <= re;                      // data arrives with it
			if (re && (rd_ptr == '0))
				valid_out <= 1'b1;          // rises with first ceo
			else if (ceo && !reading)
				valid_out <= 1'b0;          // falls after last ceo
		end
	end

	// next verdict must not arrive before this block has drained
	a_no_overlap : assert property (@(posedge clk) disable iff (reset)
		s_ready |-> !(valid_out || reading))
		else $error("out_stage: s_ready while a block is still playing out");

endmodule

//--- rs_check_top.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_check_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              ce,         // one per received byte
	input  gf_pkg::gf_elem_t  in_byte,
	output gf_pkg::gf_elem_t  out_byte,
	output logic              ceo,
	output logic              valid_out,
	output logic              block_ok    // verdict of the block on out_byte
);

	import gf_pkg::*;
	import rs_pkg::*;

	////////////////////
	// stage wires
	////////////////////
	logic      we0, we1;                    // bank writes
	byte_idx_t wr_addr;
	gf_elem_t  wr_data;
	logic      sym_strobe, sym_first, sym_last;
	gf_elem_t  sym_byte;
	bank_t     fill_bank;
	logic      s_ready;
	logic      s_ok;                        // verdict from syndromes
	bank_t     done_bank;
	logic      re0, re1;                    // bank reads
	byte_idx_t rd_addr;
	gf_elem_t  rd_data0, rd_data1;

	input_stage u_input_stage (
		.clk(clk), .reset(reset), .ce(ce), .in_byte(in_byte),
		.we0(we0), .we1(we1), .wr_addr(wr_addr), .wr_data(wr_data),
		.sym_strobe(sym_strobe), .sym_first(sym_first), .sym_last(sym_last),
		.sym_byte(sym_byte), .fill_bank(fill_bank)
	);

	syndrome_calc u_syndrome_calc (
		.clk(clk), .reset(reset),
		.sym_strobe(sym_strobe), .sym_first(sym_first), .sym_last(sym_last),
		.sym_byte(sym_byte), .fill_bank(fill_bank),
		.s_ready(s_ready), .block_ok(s_ok), .done_bank(done_bank)
	);

	////////////////////
	// ping-pong banks
	////////////////////
	block_ram #(.depth(`RS_BANK_DEPTH), .width($bits(gf_elem_t))) u_bank0 (
		.clk(clk), .we(we0), .re(re0), .wr_addr(wr_addr), .rd_addr(rd_addr),
		.wr_data(wr_data), .rd_data(rd_data0)
	);

	block_ram #(.depth(`RS_BANK_DEPTH), .width($bits(gf_elem_t))) u_bank1 (
		.clk(clk), .we(we1), .re(re1), .wr_addr(wr_addr), .rd_addr(rd_addr),
		.wr_data(wr_data), .rd_data(rd_data1)
	);

	out_stage u_out_stage (
		.clk(clk), .reset(reset),
		.s_ready(s_ready), .ok_in(s_ok), .done_bank(done_bank),
		.re0(re0), .re1(re1), .rd_addr(rd_addr),
		.rd_data0(rd_data0), .rd_data1(rd_data1),
		.out_byte(out_byte), .ceo(ceo), .valid_out(valid_out), .block_ok(block_ok)
	);

endmodule

//--- rs_config.svh
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

////////////////////
// block framing
////////////////////
`define RS_N            204     // received block, data plus parity
`define RS_K            188     // data bytes kept per block
`define RS_PARITY       16      // parity bytes = number of syndromes

////////////////////
// output pacing and storage
////////////////////
`define RS_OUT_SPACING  8       // clocks between ceo pulses
`define RS_BANK_DEPTH   `RS_K   // one bank holds the data part only

// generator polynomial x^8+x^4+x^3+x^2+1, the x^8 term is implied
`define GF_POLY         8'h1d

`endif

//--- rs_golden.txt
# name  seed(hex)  err_pos(dec, 0 = first byte sent)  err_val(hex, 00 = none)  ok(1 = clean)
# positions 0..187 are data, 188..203 parity; blocks run back to back
clean_first    00000001    0  00  1
data_err_head  0000a5a5    0  5c  0
clean_second   13579bdf   42  00  1
data_err_mid   2468ace0  100  01  0
data_err_tail  0badf00d  187  ff  0
parity_err     deadbeef  188  37  0
parity_tail    cafef00d  203  80  0
clean_last     7e57da7a   17  00  1

//--- rs_pkg.sv
`include "rs_config.svh"

package rs_pkg;

	////////////////////
	// framing types
	////////////////////

	// byte position inside one received block, 0 .. RS_N-1
	// 8 bits are enough for both the block count and the bank depth
	typedef logic [7:0] byte_idx_t;

	// which of the two ping-pong banks, 0 or 1
	typedef logic bank_t;

endpackage

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_rs_check \
	-Mdir obj_dir -o sim_rs_check > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_rs_check > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && { echo "failures found in sim.log"; exit 1; } || exit 0

//--- syndrome_calc.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module syndrome_calc (
	input  logic               clk,
	input  logic               reset,
	input  logic               sym_strobe,
	input  logic               sym_first,
	input  logic               sym_last,
	input  gf_pkg::gf_elem_t   sym_byte,
	input  rs_pkg::bank_t      fill_bank,   // already toggled when sym_last arrives
	output logic               s_ready,     // one clock, verdict valid
	output logic               block_ok,    // all syndromes zero
	output rs_pkg::bank_t      done_bank    // bank that holds the checked block
);

	import gf_pkg::*;

	gf_elem_t acc      [`RS_PARITY];        // S_j partial sums
	gf_elem_t acc_next [`RS_PARITY];
	logic     all_zero;
	logic     in_block;                     // between first and last byte

	////////////////////
	// Horner step, root alpha^j
	////////////////////
	always_comb
	begin
		for (int j = 0; j < `RS_PARITY; j++)
		begin
			if (sym_first)
				acc_next[j] = sym_byte;     // highest degree coefficient
			else
				acc_next[j] = gf_mul_alpha_pow(acc[j], j) ^ sym_byte;
		end
	end

	// verdict looks at the values being loaded, so it lines up with s_ready
	always_comb
	begin
		all_zero = 1'b1;
		for (int j = 0; j < `RS_PARITY; j++)
		begin
			if (acc_next[j] != '0)
				all_zero = 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (sym_strobe)
		begin
			for (int j = 0; j < `RS_PARITY; j++)
				acc[j] <= acc_next[j];  // all 16 in one clock
		end
	end

	////////////////////
	// verdict and bank handoff
	////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			s_ready   <= 1'b0;
			block_ok  <= 1'b0;
			done_bank <= 1'b0;
			in_block  <= 1'b0;
		end
		else
		begin
			s_ready <= sym_strobe && sym_last;
			if (sym_strobe && sym_first)
				in_block <= 1'b1;
			if (sym_strobe && sym_last)
			begin
				in_block  <= 1'b0;
				block_ok  <= all_zero;
				done_bank <= ~fill_bank;    // the bank just closed
			end
		end
	end

	// framing from input_stage stays consistent
	a_last_after_first : assert property (@(posedge clk) disable iff (reset)
		(sym_strobe && sym_last) |-> (in_block || sym_first))
		else $error("syndrome_calc: sym_last without sym_first");

endmodule

//--- tb.f
+incdir+.
gf_pkg.sv
rs_pkg.sv
block_ram.sv
input_stage.sv
syndrome_calc.sv
out_stage.sv
rs_check_top.sv
tb_clock.sv
tb_rs_check.sv

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real period       = 20.0,    // ns
	parameter int  reset_cycles = 3        // rising edges spent in reset
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk   = 1'b0;
		reset = 1'b1;                      // asserted from time zero
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;                      // released just after an edge
	end

	always #(period / 2.0) clk = ~clk;

endmodule

//--- tb_rs_check.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module tb_rs_check;

	import gf_pkg::*;

	localparam int max_tests   = 16;
	localparam int drive_skew  = 2;                        // ns after the rising edge
	localparam int first_delay = 2 + `RS_OUT_SPACING;      // last ce to first ceo

	logic     clk;
	logic     reset;
	logic     ce      = 1'b0;
	gf_elem_t in_byte = 8'h00;
	gf_elem_t out_byte;
	logic     ceo;
	logic     valid_out;
	logic     block_ok;

	// test table, filled from the golden file
	string       names    [max_tests];
	logic        exp_ok   [max_tests];
	gf_elem_t    tx_byte  [max_tests][`RS_N];  // as sent, error already applied
	gf_elem_t    exp_byte [max_tests][`RS_K];  // what out_byte must carry
	gf_elem_t    gen      [`RS_PARITY + 1];    // generator poly, gen[16] = 1
	int          n_tests  = 0;
	logic        loaded   = 1'b0;
	logic [31:0] lcg_state = 32'h006d3567;

	// monitor state
	int    cyc          = 0;                   // negedge count
	int    ce_seen      = 0;
	int    last_ce_cyc  [max_tests];           // clock of byte 203 per block
	int    blk          = 0;                   // block now playing out
	int    byte_cnt     = 0;
	int    prev_ceo_cyc = 0;
	logic  prev_valid   = 1'b0;
	logic  extra_seen   = 1'b0;
	string err_line     = "";                  // first failure of this block
	int    n_pass       = 0;
	int    n_fail       = 0;
	int    n_other      = 0;                   // failures outside any test

	tb_clock u_tb_clock (.clk(clk), .reset(reset));

	rs_check_top u_rs_check_top (
		.clk(clk), .reset(reset), .ce(ce), .in_byte(in_byte),
		.out_byte(out_byte), .ceo(ceo), .valid_out(valid_out), .block_ok(block_ok)
	);

	////////////////////
	// stimulus helpers
	////////////////////
	function automatic gf_elem_t lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];                // upper bits, better spread
	endfunction

	// product of (x + alpha^j) for j = 0..15
	task automatic build_generator();
		gf_elem_t root;
		for (int i = 0; i <= `RS_PARITY; i++)
			gen[i] = 8'h00;
		gen[0] = 8'h01;
		for (int j = 0; j < `RS_PARITY; j++)
		begin
			root = gf_mul_alpha_pow(8'h01, j);
			for (int i = j + 1; i > 0; i--)
				gen[i] = gen[i - 1] ^ gf_mul(gen[i], root);
			gen[0] = gf_mul(gen[0], root);
		end
	endtask

	// systematic encoder, remainder of m(x)*x^16 by g(x)
	task automatic encode_block(int t);
		gf_elem_t par [`RS_PARITY];
		gf_elem_t fb;
		for (int i = 0; i < `RS_PARITY; i++)
			par[i] = 8'h00;
		for (int k = 0; k < `RS_K; k++)
		begin
			fb = tx_byte[t][k] ^ par[`RS_PARITY - 1];  // division feedback
			for (int i = `RS_PARITY - 1; i > 0; i--)
				par[i] = par[i - 1] ^ gf_mul(fb, gen[i]);
			par[0] = gf_mul(fb, gen[0]);
		end
		for (int i = 0; i < `RS_PARITY; i++)
			tx_byte[t][`RS_K + i] = par[`RS_PARITY - 1 - i];   // highest degree first
	endtask

	task automatic load_golden();
		int          fd;
		int          n;
		string       line;
		string       nm;
		logic [31:0] seed;
		int          pos;
		logic [7:0]  val;
		int          ok;
		fd = $fopen("rs_golden.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd) && n_tests < max_tests)
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue;                       // blank or column notes
			n = $sscanf(line, "%s %h %d %h %d", nm, seed, pos, val, ok);
			if (n != 5)
				continue;
			names[n_tests]  = nm;
			exp_ok[n_tests] = (ok != 0);
			lcg_state = 32'h006d3567 ^ seed;    // base stream mixed with the line seed
			for (int k = 0; k < `RS_K; k++)
				tx_byte[n_tests][k] = lcg_byte();
			encode_block(n_tests);
			if (pos >= 0 && pos < `RS_N)
				tx_byte[n_tests][pos] = tx_byte[n_tests][pos] ^ val;  // 00 leaves it clean
			for (int k = 0; k < `RS_K; k++)
				exp_byte[n_tests][k] = tx_byte[n_tests][k];  // stored as received, parity dropped
			n_tests++;
		end
		$fclose(fd);
	endtask

	// one byte every RS_OUT_SPACING clocks, ce high for one clock
	task automatic send_byte(gf_elem_t b);
		@(posedge clk);
		#drive_skew;
		ce      = 1'b1;
		in_byte = b;
		@(posedge clk);
		#drive_skew;
		ce = 1'b0;
		repeat (`RS_OUT_SPACING - 2) @(posedge clk);
	endtask

	////////////////////
	// monitor
	////////////////////
	task automatic note_err(string s);
		if (err_line == "")
			err_line = s;                       // keep the first one only
	endtask

	task automatic take_ceo();
		int gap;
		if (byte_cnt == 0)
		begin
			gap = cyc - last_ce_cyc[blk];
			if (last_ce_cyc[blk] < 0)
				note_err($sformatf("test %s: output began before its block was received",
					names[blk]));
			else if (gap != first_delay)
				note_err($sformatf("ERR %s: first ceo delay expected %0d actual %0d",
					names[blk], first_delay, gap));
		end
		else
		begin
			gap = cyc - prev_ceo_cyc;
			if (gap != `RS_OUT_SPACING)
				note_err($sformatf("ERR %s: ceo spacing expected %0d actual %0d",
					names[blk], `RS_OUT_SPACING, gap));
		end
		if (byte_cnt < `RS_K && out_byte != exp_byte[blk][byte_cnt])
			note_err($sformatf("ERR %s: byte %0d expected %02h actual %02h",
				names[blk], byte_cnt, exp_byte[blk][byte_cnt], out_byte));
		if (block_ok != exp_ok[blk])
			note_err($sformatf("ERR %s: block_ok expected %0b actual %0b",
				names[blk], exp_ok[blk], block_ok));
		if (!valid_out)
			note_err($sformatf("test %s: ceo pulsed while valid_out was low", names[blk]));
		byte_cnt++;
		prev_ceo_cyc = cyc;
	endtask

	// valid_out fell, close the block
	task automatic finish_block();
		if (blk >= n_tests)
			return;
		if (byte_cnt != `RS_K)
			note_err($sformatf("ERR %s: ceo count expected %0d actual %0d",
				names[blk], `RS_K, byte_cnt));
		if (err_line == "")
		begin
			$display("pass %s: %0d bytes, block_ok %0b", names[blk], byte_cnt, exp_ok[blk]);
			n_pass++;
		end
		else
		begin
			$display("%s", err_line);
			n_fail++;
		end
		err_line = "";
		byte_cnt = 0;
		blk++;
	endtask

	// negedge sampling, all DUT outputs are settled here
	always @(negedge clk)
	begin
		cyc = cyc + 1;
		if (ce)
		begin
			ce_seen = ce_seen + 1;
			if (ce_seen % `RS_N == 0 && ce_seen <= max_tests * `RS_N)
				last_ce_cyc[ce_seen / `RS_N - 1] = cyc;   // byte 203 goes in next edge
		end
		if (ceo && blk >= n_tests)
		begin
			if (!extra_seen)
			begin
				$display("an extra output block appeared after the last test");
				n_other++;
				extra_seen = 1'b1;
			end
		end
		else if (ceo)
			take_ceo();
		if (valid_out && !prev_valid && !ceo)
		begin
			$display("valid_out rose without a ceo");
			n_other++;
		end
		if (prev_valid && !valid_out)
			finish_block();
		prev_valid = valid_out;
	end

	////////////////////
	// main sequence
	////////////////////
	initial
	begin
		for (int t = 0; t < max_tests; t++)
			last_ce_cyc[t] = -1;
		build_generator();
		load_golden();
		loaded = 1'b1;
		if (n_tests == 0)
		begin
			$display("no test blocks could be read from rs_golden.txt");
			n_other++;
		end
		else
		begin
			@(negedge reset);
			for (int t = 0; t < n_tests; t++)   // back to back, banks alternate
				for (int k = 0; k < `RS_N; k++)
					send_byte(tx_byte[t][k]);
			wait (blk >= n_tests);
			repeat (4 * `RS_OUT_SPACING) @(posedge clk);   // catch a stray ceo
		end
		$display("tests %0d  passed %0d  failed %0d  other errors %0d",
			n_tests, n_pass, n_fail, n_other);
		if (n_tests > 0 && n_pass == n_tests && n_fail == 0 && n_other == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog, twice the time all blocks need at full spacing
	initial
	begin
		int limit;
		wait (loaded);
		limit = 2 * n_tests * `RS_N * `RS_OUT_SPACING;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d clocks", limit);
		for (int t = blk; t < n_tests; t++)
			$display("test %s: no complete output block was seen", names[t]);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
